// File: bench/platform_trace.txt
# Columns: op addr data resp, in hex. W writes data, R expects data; resp 0 OKAY, 2 SLVERR
# P polls CTRL until the done bit is set
R 00 00000000 0
W 04 00000010 0
W 08 00000008 0
W 0C 00000005 0
R 04 00000010 0
R 08 00000008 0
R 0C 00000005 0
W 00 00000001 0
P
R 00 00000002 0
R 10 00000044 0
R 14 00000000 0
R 18 00000002 0
W 08 0000000A 0
W 0C 00000100 0
W 04 00000040 0
W 00 00000001 0
P
R 10 00000A2D 0
R 14 00000000 0
R 18 00000003 0
W 04 00000080 0
W 08 00000020 0
W 0C FFFFFFF0 0
W 00 00000001 0
P
R 10 FFFFFFF0 0
R 14 0000001F 0
R 18 00000008 0
R 40 00000000 2
W 10 12345678 2
R 10 FFFFFFF0 0
W 08 00000000 0
W 00 00000001 0
P
R 10 00000000 0
R 14 00000000 0
R 18 00000000 0
W 04 00000200 0
W 08 0000000C 0
W 0C 00001000 0
W 00 00000001 0
W 0C 00002000 0
W 00 00000001 0
P
R 0C 00002000 0
R 10 0000C042 0
R 14 00000000 0
R 18 00000003 0

// File: project.f
source/ofs_plat_pkg.sv
source/local_mem_if.sv
source/afu_cmd_if.sv
source/local_mem_model.sv
source/mem_write_response_gen.sv
source/afu_csr_decode.sv
source/afu_fill_engine.sv
source/afu_result_collect.sv
source/ase_top_ofs_plat.sv
bench/tb_ase_top.sv

// File: bench/tb_ase_top.sv
//------------------------------
// Platform testbench
// Replays the register trace over AXI4-Lite and checks the responses
//------------------------------

module tb_ase_top;

    localparam int    CLK_PERIOD      = 20;
    localparam int    POLL_LIMIT      = 500;
    localparam int    WATCHDOG_CYCLES = 2000;
    localparam string TRACE_FILE      = "bench/platform_trace.txt";

    logic                    pClk;
    logic                    rst_n;
    ofs_plat_pkg::csr_addr_t awaddr;
    logic                    awvalid;
    logic                    awready;
    ofs_plat_pkg::csr_data_t wdata;
    logic                    wvalid;
    logic                    wready;
    ofs_plat_pkg::axi_resp_t bresp;
    logic                    bvalid;
    logic                    bready;
    ofs_plat_pkg::csr_addr_t araddr;
    logic                    arvalid;
    logic                    arready;
    ofs_plat_pkg::csr_data_t rdata;
    ofs_plat_pkg::axi_resp_t rresp;
    logic                    rvalid;
    logic                    rready;

    // Trace contents, one entry per W, R or P line
    byte                     op_q [$];
    ofs_plat_pkg::csr_addr_t addr_q [$];
    ofs_plat_pkg::csr_data_t data_q [$];
    ofs_plat_pkg::axi_resp_t resp_q [$];
    int                      n_ops = 0;
    int                      data_errors = 0;
    int                      resp_errors = 0;
    int                      other_errors = 0;

    ase_top_ofs_plat #(.BURST_LEN(4), .READ_LATENCY(3), .MEM_WORDS(1024)) DUT
    (
        .pClk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    initial
    begin
        pClk = 1'b0;
        forever #(CLK_PERIOD / 2) pClk = ~pClk;
    end

    task automatic check_data(input string name, input ofs_plat_pkg::csr_data_t expected,
                              input ofs_plat_pkg::csr_data_t actual);
        if (actual !== expected)
        begin
            data_errors++;
            $display("ERROR: time %0t %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_resp(input string name, input ofs_plat_pkg::axi_resp_t expected,
                              input ofs_plat_pkg::axi_resp_t actual);
        if (actual !== expected)
        begin
            resp_errors++;
            $display("ERROR: time %0t %s expected %0d actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    // Holds a ready low for 0 to 3 cycles to exercise back-pressure
    task automatic random_stall();
        repeat ($urandom % 4) @(posedge pClk);
    endtask

    // Called on a rising edge; handshake signals are sampled at the edge they complete on
    task automatic axi_write(input ofs_plat_pkg::csr_addr_t addr,
                             input ofs_plat_pkg::csr_data_t data,
                             output ofs_plat_pkg::axi_resp_t resp);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        @(posedge pClk);
        while (!(awready && wready))
            @(posedge pClk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        random_stall();
        bready <= 1'b1;
        @(posedge pClk);
        while (!bvalid)
            @(posedge pClk);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input ofs_plat_pkg::csr_addr_t addr,
                            output ofs_plat_pkg::csr_data_t data,
                            output ofs_plat_pkg::axi_resp_t resp);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge pClk);
        while (!arready)
            @(posedge pClk);
        arvalid <= 1'b0;
        random_stall();
        rready <= 1'b1;
        @(posedge pClk);
        while (!rvalid)
            @(posedge pClk);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    // Done is bit 1 of CTRL
    task automatic poll_done();
        ofs_plat_pkg::csr_data_t data;
        ofs_plat_pkg::axi_resp_t resp;
        int                      polls;
        logic                    finished;
        polls    = 0;
        finished = 1'b0;
        while (!finished && polls < POLL_LIMIT)
        begin
            axi_read(ofs_plat_pkg::REG_CTRL, data, resp);
            check_resp("rresp", ofs_plat_pkg::RESP_OKAY, resp);
            finished = data[1];
            polls++;
        end
        if (!finished)
        begin
            other_errors++;
            $display("FAILURE at time %0t: the job never completed after %0d polls of CTRL",
                     $time, POLL_LIMIT);
        end
    endtask

    // Loads the whole trace up front so the watchdog knows its length
    task automatic load_trace();
        int          fd;
        int          fields;
        string       line;
        byte         op;
        int unsigned f_addr;
        int unsigned f_data;
        int unsigned f_resp;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("FAILURE: the trace file %s could not be opened", TRACE_FILE);
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                fields = $sscanf(line, "%c %h %h %h", op, f_addr, f_data, f_resp);
                // Comment and blank lines fall through without an entry
                if (op == "P" || ((op == "W" || op == "R") && fields == 4))
                begin
                    op_q.push_back(op);
                    addr_q.push_back(ofs_plat_pkg::csr_addr_t'(f_addr));
                    data_q.push_back(ofs_plat_pkg::csr_data_t'(f_data));
                    resp_q.push_back(ofs_plat_pkg::axi_resp_t'(f_resp));
                end
            end
            $fclose(fd);
        end
        n_ops = op_q.size();
    endtask

    initial
    begin
        int unsigned             rng_seed;
        ofs_plat_pkg::csr_data_t rd_data;
        ofs_plat_pkg::axi_resp_t resp;
        rng_seed = 32'h2432_cf7f;
        void'($urandom(rng_seed));
        rst_n   <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        load_trace();
        repeat (2) @(posedge pClk);
        rst_n <= 1'b1;
        @(posedge pClk);
        for (int i = 0; i < n_ops; i++)
        begin
            case (op_q[i])
                "W":
                begin
                    axi_write(addr_q[i], data_q[i], resp);
                    check_resp("bresp", resp_q[i], resp);
                end
                "R":
                begin
                    axi_read(addr_q[i], rd_data, resp);
                    check_data("rdata", data_q[i], rd_data);
                    check_resp("rresp", resp_q[i], resp);
                end
                default:
                    poll_done();
            endcase
        end
        @(posedge pClk);
        $display("Summary: %0d data errors, %0d response errors, %0d other errors",
                 data_errors, resp_errors, other_errors);
        if (data_errors + resp_errors + other_errors == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Budget grows with the trace, each entry gets a fixed number of cycles
    initial
    begin
        wait (n_ops > 0);
        repeat (n_ops * WATCHDOG_CYCLES) @(posedge pClk);
        $display("FAILURE at time %0t: the run did not finish within the cycle budget", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: source/ase_top_ofs_plat.sv
//------------------------------
// Simulated platform top
// Builds the memory bank, its write responses and the AFU around the CSR port
//------------------------------

module ase_top_ofs_plat
#(
    parameter int BURST_LEN    = 4,
    parameter int READ_LATENCY = 3,
    parameter int MEM_WORDS    = 1024
)
(
    input  logic                    pClk,
    input  logic                    rst_n,
    input  ofs_plat_pkg::csr_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  ofs_plat_pkg::csr_data_t wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output ofs_plat_pkg::axi_resp_t bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  ofs_plat_pkg::csr_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output ofs_plat_pkg::csr_data_t rdata,
    output ofs_plat_pkg::axi_resp_t rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    // Single bank, shared by the AFU, the model and the response generator
    local_mem_if mem_if();
    afu_cmd_if   cmd_if();

    local_mem_model #(.READ_LATENCY(READ_LATENCY), .MEM_WORDS(MEM_WORDS)) mem_model
    (
        .pClk,
        .rst_n,
        .mem(mem_if.slave)
    );

    // The bank model has no write responses of its own
    mem_write_response_gen wr_resp
    (
        .pClk,
        .rst_n,
        .mem(mem_if.resp_gen)
    );

    afu_csr_decode csr_decode
    (
        .pClk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .cmd(cmd_if.decode)
    );

    afu_fill_engine #(.BURST_LEN(BURST_LEN)) fill_engine
    (
        .pClk,
        .rst_n,
        .cmd(cmd_if.execute),
        .mem(mem_if.master)
    );

    afu_result_collect result_collect
    (
        .pClk,
        .rst_n,
        .cmd(cmd_if.result),
        .mem(mem_if.monitor)
    );

endmodule

// File: source/afu_result_collect.sv
//------------------------------
// AFU result stage
// Checksums the read-back data and counts write responses
//------------------------------

module afu_result_collect
(
    input  logic         pClk,
    input  logic         rst_n,
    afu_cmd_if.result    cmd,
    local_mem_if.monitor mem
);

    logic busy_q;

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy_q            <= 1'b0;
            cmd.done          <= 1'b0;
            cmd.checksum      <= '0;
            cmd.wr_resp_count <= '0;
        end
        else
        begin
            busy_q <= cmd.busy;
            if (cmd.start)
            begin
                // A new job wipes the previous results
                cmd.done          <= 1'b0;
                cmd.checksum      <= '0;
                cmd.wr_resp_count <= '0;
            end
            else
            begin
                // Wrapping 64-bit sum, carries reach the upper word
                if (mem.readdatavalid)
                begin
                    cmd.checksum <= cmd.checksum + mem.readdata;
                end
                if (mem.writeresponsevalid)
                begin
                    cmd.wr_resp_count <= cmd.wr_resp_count + 1'b1;
                end
                // The engine drops busy only after the last read beat
                if (busy_q && !cmd.busy)
                begin
                    cmd.done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: source/afu_fill_engine.sv
//------------------------------
// AFU fill engine
// Writes seed + i in bursts, waits for the write responses, then reads back
//------------------------------

module afu_fill_engine
#(
    parameter int BURST_LEN = 4
)
(
    input  logic        pClk,
    input  logic        rst_n,
    afu_cmd_if.execute  cmd,
    local_mem_if.master mem
);

    ofs_plat_pkg::fill_state_t state;
    ofs_plat_pkg::mem_addr_t   base_q;
    ofs_plat_pkg::line_cnt_t   len_q;
    ofs_plat_pkg::csr_data_t   seed_q;
    ofs_plat_pkg::line_cnt_t   nbursts;
    ofs_plat_pkg::line_cnt_t   idx;
    ofs_plat_pkg::line_cnt_t   idx_next;
    ofs_plat_pkg::line_cnt_t   burst_idx;
    ofs_plat_pkg::line_cnt_t   burst_end;
    ofs_plat_pkg::line_cnt_t   left;
    ofs_plat_pkg::line_cnt_t   rd_left;
    ofs_plat_pkg::burst_cnt_t  bc;
    logic                      accepted;
    logic                      launch;

    assign launch = (state == ofs_plat_pkg::IDLE) && cmd.start;

    // The last burst of a job carries whatever is left
    assign left = len_q - burst_idx;
    assign bc   = (left > ofs_plat_pkg::line_cnt_t'(BURST_LEN)) ?
                  ofs_plat_pkg::burst_cnt_t'(BURST_LEN) : ofs_plat_pkg::burst_cnt_t'(left);
    assign burst_end = burst_idx + ofs_plat_pkg::line_cnt_t'(bc);
    assign idx_next  = idx + 1'b1;
    assign accepted  = (mem.read || mem.write) && !mem.waitrequest;

    // The burst start address is held for all beats of a write burst
    assign mem.write      = (state == ofs_plat_pkg::WRITE);
    assign mem.read       = (state == ofs_plat_pkg::READ);
    assign mem.address    = base_q + ofs_plat_pkg::mem_addr_t'(burst_idx);
    assign mem.burstcount = bc;
    assign mem.writedata  = ofs_plat_pkg::mem_data_t'(seed_q) + ofs_plat_pkg::mem_data_t'(idx);
    assign cmd.busy       = (state != ofs_plat_pkg::IDLE);

    always_ff @(posedge pClk)
    begin
        if (launch)
        begin
            base_q  <= cmd.base;
            len_q   <= cmd.length;
            seed_q  <= cmd.seed;
            nbursts <= ofs_plat_pkg::line_cnt_t'((32'(cmd.length) + BURST_LEN - 1) / BURST_LEN);
        end
    end

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ofs_plat_pkg::IDLE;
            idx       <= '0;
            burst_idx <= '0;
            rd_left   <= '0;
        end
        else
        begin
            // Read beats still owed to the job, several may be in flight
            if (mem.readdatavalid && rd_left != '0)
            begin
                rd_left <= rd_left - 1'b1;
            end
            case (state)
                ofs_plat_pkg::IDLE:
                    if (cmd.start)
                    begin
                        idx       <= '0;
                        burst_idx <= '0;
                        rd_left   <= cmd.length;
                        state     <= (cmd.length == '0) ? ofs_plat_pkg::DONE : ofs_plat_pkg::WRITE;
                    end
                ofs_plat_pkg::WRITE:
                    if (accepted)
                    begin
                        idx <= idx_next;
                        if (idx_next == burst_end)
                        begin
                            burst_idx <= burst_end;
                            if (burst_end == len_q)
                            begin
                                state <= ofs_plat_pkg::WAIT_RESP;
                            end
                        end
                    end
                // The whole range must be committed before it is read back
                ofs_plat_pkg::WAIT_RESP:
                    if (cmd.wr_resp_count == nbursts)
                    begin
                        burst_idx <= '0;
                        state     <= ofs_plat_pkg::READ;
                    end
                // One request per burst, with no wait for its data
                ofs_plat_pkg::READ:
                    if (accepted)
                    begin
                        burst_idx <= burst_end;
                        if (burst_end == len_q)
                        begin
                            state <= ofs_plat_pkg::DONE;
                        end
                    end
                ofs_plat_pkg::DONE:
                    if (rd_left == '0)
                    begin
                        state <= ofs_plat_pkg::IDLE;
                    end
                default:
                    state <= ofs_plat_pkg::IDLE;
            endcase
        end
    end

endmodule

// File: source/afu_csr_decode.sv
//------------------------------
// AFU register decode
// AXI4-Lite slave with the job registers and the status read mux
//------------------------------

module afu_csr_decode
(
    input  logic                    pClk,
    input  logic                    rst_n,
    input  ofs_plat_pkg::csr_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  ofs_plat_pkg::csr_data_t wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output ofs_plat_pkg::axi_resp_t bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  ofs_plat_pkg::csr_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output ofs_plat_pkg::csr_data_t rdata,
    output ofs_plat_pkg::axi_resp_t rresp,
    output logic                    rvalid,
    input  logic                    rready,
    afu_cmd_if.decode               cmd
);

    ofs_plat_pkg::csr_data_t base_q;
    ofs_plat_pkg::csr_data_t length_q;
    ofs_plat_pkg::csr_data_t seed_q;
    ofs_plat_pkg::csr_data_t rd_word;
    ofs_plat_pkg::axi_resp_t rd_resp;
    ofs_plat_pkg::axi_resp_t wr_resp;
    logic                    wr_fire;
    logic                    rd_fire;
    logic                    start_q;

    // Address and data are taken together, only with no response pending
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign rd_fire = arvalid && !rvalid;
    assign arready = !rvalid;

    assign cmd.start  = start_q;
    assign cmd.base   = ofs_plat_pkg::mem_addr_t'(base_q);
    assign cmd.length = ofs_plat_pkg::line_cnt_t'(length_q);
    assign cmd.seed   = seed_q;

    // Only the job registers accept writes
    always_comb
    begin
        case (awaddr)
            ofs_plat_pkg::REG_CTRL, ofs_plat_pkg::REG_BASE,
            ofs_plat_pkg::REG_LENGTH, ofs_plat_pkg::REG_SEED:
                wr_resp = ofs_plat_pkg::RESP_OKAY;
            default:
                wr_resp = ofs_plat_pkg::RESP_SLVERR;
        endcase
    end

    always_comb
    begin
        rd_word = '0;
        rd_resp = ofs_plat_pkg::RESP_OKAY;
        case (araddr)
            ofs_plat_pkg::REG_CTRL:    rd_word = {30'd0, cmd.done, cmd.busy};
            ofs_plat_pkg::REG_BASE:    rd_word = base_q;
            ofs_plat_pkg::REG_LENGTH:  rd_word = length_q;
            ofs_plat_pkg::REG_SEED:    rd_word = seed_q;
            ofs_plat_pkg::REG_SUM_LO:  rd_word = cmd.checksum[31:0];
            ofs_plat_pkg::REG_SUM_HI:  rd_word = cmd.checksum[63:32];
            ofs_plat_pkg::REG_WR_RESP: rd_word = ofs_plat_pkg::csr_data_t'(cmd.wr_resp_count);
            default:                   rd_resp = ofs_plat_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            start_q  <= 1'b0;
            base_q   <= '0;
            length_q <= '0;
            seed_q   <= '0;
        end
        else
        begin
            start_q <= 1'b0;
            if (bvalid && bready)
            begin
                bvalid <= 1'b0;
            end
            if (rvalid && rready)
            begin
                rvalid <= 1'b0;
            end
            if (rd_fire)
            begin
                rvalid <= 1'b1;
            end
            if (wr_fire)
            begin
                bvalid <= 1'b1;
                case (awaddr)
                    // A start during a running job is dropped but still acknowledged
                    ofs_plat_pkg::REG_CTRL:   start_q  <= wdata[0] && !cmd.busy && !start_q;
                    ofs_plat_pkg::REG_BASE:   base_q   <= wdata;
                    ofs_plat_pkg::REG_LENGTH: length_q <= wdata;
                    ofs_plat_pkg::REG_SEED:   seed_q   <= wdata;
                    default:                  ;
                endcase
            end
        end
    end

    // Response payload, qualified by bvalid and rvalid
    always_ff @(posedge pClk)
    begin
        if (wr_fire)
        begin
            bresp <= wr_resp;
        end
        if (rd_fire)
        begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

// File: source/mem_write_response_gen.sv
//------------------------------
// Write response generator
// One writeresponsevalid pulse per finished write burst
//------------------------------

module mem_write_response_gen
(
    input  logic          pClk,
    input  logic          rst_n,
    local_mem_if.resp_gen mem
);

    // Beats still expected in the open burst, zero between bursts
    ofs_plat_pkg::burst_cnt_t beats_left;
    logic                     wr_beat;

    assign wr_beat = mem.write && !mem.waitrequest;

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beats_left             <= '0;
            mem.writeresponsevalid <= 1'b0;
        end
        else
        begin
            mem.writeresponsevalid <= 1'b0;
            if (wr_beat)
            begin
                if (beats_left == '0)
                begin
                    // First beat, the burst length is only valid here
                    beats_left             <= mem.burstcount - 1'b1;
                    mem.writeresponsevalid <= (mem.burstcount == 4'd1);
                end
                else
                begin
                    beats_left             <= beats_left - 1'b1;
                    mem.writeresponsevalid <= (beats_left == 4'd1);
                end
            end
        end
    end

endmodule

// File: source/local_mem_model.sv
//------------------------------
// Local memory bank model
// Word array with burst writes, pipelined burst reads and waitrequest
//------------------------------

module local_mem_model
#(
    parameter int READ_LATENCY = 3,
    parameter int MEM_WORDS    = 1024
)
(
    input  logic       pClk,
    input  logic       rst_n,
    local_mem_if.slave mem
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    ofs_plat_pkg::mem_data_t  mem_array [MEM_WORDS];
    ofs_plat_pkg::mem_addr_t  wr_addr;
    ofs_plat_pkg::mem_addr_t  wr_target;
    ofs_plat_pkg::burst_cnt_t wr_left;
    ofs_plat_pkg::mem_addr_t  rd_addr;
    ofs_plat_pkg::mem_addr_t  issue_addr;
    ofs_plat_pkg::burst_cnt_t rd_left;
    ofs_plat_pkg::mem_addr_t  pipe_addr [READ_LATENCY];
    logic [READ_LATENCY-1:0]  pipe_vld;
    logic                     wait_q;
    logic                     wr_beat;
    logic                     rd_start;
    logic                     burst_start;
    logic                     issue_vld;

    // One stall cycle after every burst start, and the read side also holds
    // off new bursts until the current one has been fully issued
    assign mem.waitrequest = wait_q || (rd_left != '0);

    assign wr_beat     = mem.write && !mem.waitrequest;
    assign rd_start    = mem.read && !mem.waitrequest;
    assign burst_start = rd_start || (wr_beat && wr_left == '0);

    // The first write beat carries the address, later beats follow on
    assign wr_target = (wr_left == '0) ? mem.address : wr_addr;

    // Beat 0 of a read enters the pipeline in the accept cycle
    assign issue_vld  = rd_start || (rd_left != '0);
    assign issue_addr = rd_start ? mem.address : rd_addr;

    assign mem.readdatavalid = pipe_vld[READ_LATENCY-1];
    assign mem.readdata      = mem_array[pipe_addr[READ_LATENCY-1][IDX_W-1:0]];

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wait_q   <= 1'b0;
            wr_left  <= '0;
            rd_left  <= '0;
            pipe_vld <= '0;
        end
        else
        begin
            wait_q   <= burst_start;
            pipe_vld <= (pipe_vld << 1) | issue_vld;
            if (wr_beat)
            begin
                wr_left <= (wr_left == '0) ? mem.burstcount - 1'b1 : wr_left - 1'b1;
            end
            if (rd_start)
            begin
                rd_left <= mem.burstcount - 1'b1;
            end
            else if (rd_left != '0)
            begin
                rd_left <= rd_left - 1'b1;
            end
        end
    end

    // Storage and address pipeline
    always_ff @(posedge pClk)
    begin
        if (wr_beat)
        begin
            mem_array[wr_target[IDX_W-1:0]] <= mem.writedata;
            wr_addr <= wr_target + 1'b1;
        end
        rd_addr <= issue_addr + 1'b1;
        pipe_addr[0] <= issue_addr;
        for (int i = 1; i < READ_LATENCY; i++)
        begin
            pipe_addr[i] <= pipe_addr[i-1];
        end
    end

endmodule

// File: source/afu_cmd_if.sv
//------------------------------
// AFU command and status bus
// Joins the decode, execute and result stages
//------------------------------

interface afu_cmd_if;

    logic                     start;
    ofs_plat_pkg::mem_addr_t  base;
    ofs_plat_pkg::line_cnt_t  length;
    ofs_plat_pkg::csr_data_t  seed;
    logic                     busy;
    logic                     done;
    ofs_plat_pkg::checksum_t  checksum;
    ofs_plat_pkg::line_cnt_t  wr_resp_count;

    modport decode (
        output start, base, length, seed,
        input  busy, done, checksum, wr_resp_count
    );

    // The execute stage waits on wr_resp_count before reading back
    modport execute (
        input  start, base, length, seed, wr_resp_count,
        output busy
    );

    modport result (
        input  start, busy,
        output done, checksum, wr_resp_count
    );

endinterface

// File: source/local_mem_if.sv
//------------------------------
// Local memory bank interface
// Avalon-MM style bus between the AFU and the bank model
//------------------------------

interface local_mem_if;

    ofs_plat_pkg::mem_addr_t  address;
    logic                     read;
    logic                     write;
    ofs_plat_pkg::burst_cnt_t burstcount;
    ofs_plat_pkg::mem_data_t  writedata;
    logic                     waitrequest;
    ofs_plat_pkg::mem_data_t  readdata;
    logic                     readdatavalid;
    logic                     writeresponsevalid;

    // AFU side, issues the bursts
    modport master (
        output address, read, write, burstcount, writedata,
        input  waitrequest, readdatavalid
    );

    // Bank model side
    modport slave (
        input  address, read, write, burstcount, writedata,
        output waitrequest, readdata, readdatavalid
    );

    // Watches write beats and reports completed write bursts
    modport resp_gen (
        input  write, waitrequest, burstcount,
        output writeresponsevalid
    );

    // Passive view of the returned data and write responses
    modport monitor (
        input readdata, readdatavalid, writeresponsevalid
    );

endinterface

// File: source/ofs_plat_pkg.sv
//------------------------------
// Platform shared definitions
// Widths, CSR offsets and AXI response codes used by the platform and AFU
//------------------------------

package ofs_plat_pkg;

    // Word address width of the local memory bank
    localparam int MEM_ADDR_WIDTH = 16;

    // AXI4-Lite register port
    typedef logic [7:0]  csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  axi_resp_t;

    // Local memory bank
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [63:0]               mem_data_t;
    typedef logic [3:0]                burst_cnt_t;

    // Job length in words and the result of the read-back pass
    typedef logic [15:0] line_cnt_t;
    typedef logic [63:0] checksum_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // CTRL writes start in bit 0 and reads back busy in bit 0, done in bit 1
    localparam csr_addr_t REG_CTRL    = 8'h00;
    localparam csr_addr_t REG_BASE    = 8'h04;
    localparam csr_addr_t REG_LENGTH  = 8'h08;
    localparam csr_addr_t REG_SEED    = 8'h0C;
    localparam csr_addr_t REG_SUM_LO  = 8'h10;
    localparam csr_addr_t REG_SUM_HI  = 8'h14;
    localparam csr_addr_t REG_WR_RESP = 8'h18;

    // Fill engine FSM
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        WAIT_RESP,
        READ,
        DONE
    } fill_state_t;

endpackage
